/* cmult_settings.svh */
`ifndef CMULT_SETTINGS_SVH
`define CMULT_SETTINGS_SVH

// ********************
// Fixed-point format
// ********************

// Word width of every operand and result.
`define CMULT_WIDTH 32

// Fraction bits. Must stay below CMULT_WIDTH.
`define CMULT_FRAC 16

`endif

/* cmult_pkg.sv */
`include "cmult_settings.svh"

package cmult_pkg;

	// ********************
	// Data types
	// ********************

	typedef logic signed [`CMULT_WIDTH-1:0] fixed_t; // One signed fixed-point word.

	typedef logic [2*`CMULT_WIDTH-1:0] acc_t; // Unsigned double-width product.

	// Real part sits in the upper half.
	typedef struct packed {
		fixed_t re;
		fixed_t im;
	} complex_t;

	// ********************
	// Control encodings
	// ********************

	typedef enum logic [2:0] {
		idle,
		sum_prod,
		real_prod,
		imag_prod,
		done
	} cmult_state_t;

	// Selects which product the datapath feeds to the multiplier.
	typedef enum logic [1:0] {
		stage_sum,
		stage_real,
		stage_imag,
		stage_none
	} mult_stage_t;

endpackage

/* fixed_iter_multiplier.sv */
`include "cmult_settings.svh"

module fixed_iter_multiplier import cmult_pkg::*; #(
	parameter int WIDTH = `CMULT_WIDTH,
	parameter int FRAC = `CMULT_FRAC
) (
	input logic clk,
	input logic reset,
	input fixed_t a,
	input fixed_t b,
	input logic recv_val,
	output logic recv_rdy,
	output logic send_val,
	output fixed_t p
);
	localparam int CNT_W = (WIDTH > 1) ? $clog2(WIDTH) : 1;

	typedef enum logic [1:0] {
		mul_idle,
		mul_run,
		mul_finish
	} mul_state_t;

	mul_state_t state;
	mul_state_t next_state;
	logic [CNT_W-1:0] count;
	logic [WIDTH-1:0] mag_a;
	logic [WIDTH-1:0] mag_b;
	logic [WIDTH-1:0] mplier;
	acc_t mcand;
	acc_t acc;
	acc_t product;
	acc_t shifted;
	logic neg;

	generate
		if (WIDTH != $bits(fixed_t) || FRAC >= WIDTH) begin : g_param_check
			$error("fixed_iter_multiplier: WIDTH must match fixed_t and exceed FRAC");
		end
	endgenerate

	// The most negative word maps onto 2^(WIDTH-1), which still fits unsigned.
	assign mag_a = a[WIDTH-1] ? -a : a;
	assign mag_b = b[WIDTH-1] ? -b : b;

	// ********************
	// Sequencer
	// ********************

	always_ff @(posedge clk) begin
		if (reset)
			state <= mul_idle;
		else
			state <= next_state;
	end

	always_comb begin
		next_state = state;
		case (state)
			mul_idle: begin
				if (recv_val)
					next_state = mul_run;
			end
			mul_run: begin
				if (count == CNT_W'(WIDTH - 1))
					next_state = mul_finish; // Last partial product goes in on this edge.
			end
			mul_finish: next_state = mul_idle;
			default: next_state = mul_idle;
		endcase
	end

	assign recv_rdy = (state == mul_idle);
	assign send_val = (state == mul_finish);

	// ********************
	// Shift and add
	// ********************

	always_ff @(posedge clk) begin
		case (state)
			mul_idle: begin
				if (recv_val) begin
					mplier <= mag_b;
					mcand <= acc_t'(mag_a);
					acc <= '0;
					neg <= a[WIDTH-1] ^ b[WIDTH-1];
					count <= '0;
				end
			end
			mul_run: begin
				if (mplier[0])
					acc <= acc + mcand;
				mcand <= mcand << 1; // Weight of the next multiplier bit.
				mplier <= mplier >> 1;
				count <= count + 1'b1;
			end
			default: begin
			end
		endcase
	end

	// Sign is restored on the full product so the shift below floors.
	assign product = neg ? -acc : acc;
	assign shifted = $signed(product) >>> FRAC;
	assign p = shifted[WIDTH-1:0];

	a_send_one_cycle: assert property (
		@(posedge clk) disable iff (reset) send_val |=> !send_val
	);

endmodule

/* cmult_control.sv */
module cmult_control import cmult_pkg::*; (
	input logic clk,
	input logic reset,
	input logic recv_val,
	output logic recv_rdy,
	output logic send_val,
	input logic send_rdy,
	input logic mul_ready,
	input logic mul_done,
	output logic load,
	output mult_stage_t stage
);
	cmult_state_t state;
	cmult_state_t next_state;
	logic accept;

	assign accept = recv_val && recv_rdy;

	// ********************
	// State register
	// ********************

	always_ff @(posedge clk) begin
		if (reset)
			state <= idle;
		else
			state <= next_state;
	end

	// Each product state waits for the multiplier's one-cycle result.
	always_comb begin
		next_state = state;
		case (state)
			idle: begin
				if (accept)
					next_state = sum_prod;
			end
			sum_prod: begin
				if (mul_done)
					next_state = real_prod;
			end
			real_prod: begin
				if (mul_done)
					next_state = imag_prod;
			end
			imag_prod: begin
				if (mul_done)
					next_state = done;
			end
			done: begin
				if (send_rdy)
					next_state = idle;
			end
			default: next_state = idle;
		endcase
	end

	// ********************
	// Output decode
	// ********************

	assign load = (state == idle); // Inputs are sampled every idle cycle.
	assign recv_rdy = (state == idle) && mul_ready;
	assign send_val = (state == done);

	always_comb begin
		case (state)
			sum_prod: stage = stage_sum;
			real_prod: stage = stage_real;
			imag_prod: stage = stage_imag;
			default: stage = stage_none;
		endcase
	end

	a_rdy_val_exclusive: assert property (
		@(posedge clk) disable iff (reset) !(recv_rdy && send_val)
	);

	a_no_stage_outside_products: assert property (
		@(posedge clk) disable iff (reset)
		(state inside {idle, done}) |-> (stage == stage_none)
	);

endmodule

/* cmult_datapath.sv */
module cmult_datapath import cmult_pkg::*; (
	input logic clk,
	input logic reset,
	input complex_t a,
	input complex_t b,
	input logic load,
	input mult_stage_t stage,
	output logic mul_ready,
	output logic mul_done,
	output complex_t c
);
	fixed_t ar;
	fixed_t ac;
	fixed_t br;
	fixed_t bc;
	fixed_t t0;
	fixed_t mul_a;
	fixed_t mul_b;
	fixed_t mul_p;
	logic mul_req;

	// ********************
	// Operand and product registers
	// ********************

	// ar and ac are reused for t1 and t2 once their operands are consumed.
	always_ff @(posedge clk) begin
		if (load) begin
			ar <= a.re;
			ac <= a.im;
			br <= b.re;
			bc <= b.im;
		end else if (mul_done) begin
			case (stage)
				stage_sum: t0 <= mul_p;
				stage_real: ar <= mul_p; // t1 = ar * br.
				stage_imag: ac <= mul_p; // t2 = ac * bc.
				default: begin
				end
			endcase
		end
	end

	// ********************
	// Multiplier operand select
	// ********************

	always_comb begin
		case (stage)
			stage_sum: begin
				mul_a = ar + ac; // Sums wrap at the word width.
				mul_b = br + bc;
			end
			stage_imag: begin
				mul_a = ac;
				mul_b = bc;
			end
			default: begin
				mul_a = ar;
				mul_b = br;
			end
		endcase
	end

	assign mul_req = (stage != stage_none);

	fixed_iter_multiplier mult0 (
		.clk(clk),
		.reset(reset),
		.a(mul_a),
		.b(mul_b),
		.recv_val(mul_req),
		.recv_rdy(mul_ready),
		.send_val(mul_done),
		.p(mul_p)
	);

	// Real part is t1 - t2, imaginary part is t0 - t1 - t2.
	assign c = '{re: ar - ac, im: t0 - ar - ac};

	a_done_only_in_stage: assert property (
		@(posedge clk) disable iff (reset) mul_done |-> (stage != stage_none)
	);

endmodule

/* cmult_top.sv */
module cmult_top import cmult_pkg::*; (
	input logic clk,
	input logic reset,
	input logic recv_val,
	output logic recv_rdy,
	input complex_t a,
	input complex_t b,
	output logic send_val,
	input logic send_rdy,
	output complex_t c
);
	logic load;
	mult_stage_t stage;
	logic mul_ready;
	logic mul_done;

	// Sequences the three products and both handshakes.
	cmult_control control0 (
		.clk(clk),
		.reset(reset),
		.recv_val(recv_val),
		.recv_rdy(recv_rdy),
		.send_val(send_val),
		.send_rdy(send_rdy),
		.mul_ready(mul_ready),
		.mul_done(mul_done),
		.load(load),
		.stage(stage)
	);

	cmult_datapath datapath0 (
		.clk(clk),
		.reset(reset),
		.a(a),
		.b(b),
		.load(load),
		.stage(stage),
		.mul_ready(mul_ready),
		.mul_done(mul_done),
		.c(c)
	);

endmodule

/* tb_clock.sv */
module tb_clock #(
	parameter int PERIOD = 4
) (
	output logic clk
);

	initial clk = 1'b0;

	always #(PERIOD / 2) clk = ~clk; // Rising edges at 2, 6, 10 and so on.

endmodule

/* cmult_tb.sv */
`include "cmult_settings.svh"

module cmult_tb import cmult_pkg::*; ();
	localparam int W = `CMULT_WIDTH;
	localparam int FRAC = `CMULT_FRAC;
	localparam int RESET_CYCLES = 10;
	localparam int LATENCY = 3 * (W + 2);
	localparam int N_DIRECTED = 8;
	localparam int N_RANDOM = 200;
	localparam int N_STALL = 40;
	localparam int N_TIMING = 20;
	localparam int N_TRANS = N_DIRECTED + N_RANDOM + N_STALL + N_TIMING;
	localparam int TIMEOUT_CYCLES = N_TRANS * (LATENCY + 20) + RESET_CYCLES;
	localparam fixed_t ONE = fixed_t'(1) <<< FRAC;

	logic clk;
	logic reset;
	logic recv_val;
	logic recv_rdy;
	complex_t a;
	complex_t b;
	logic send_val;
	logic send_rdy;
	complex_t c;

	complex_t exp_q[$]; // Expected results in issue order.
	int errors = 0;
	int cycles = 0;
	int accept_cycle = 0;
	int accepted = 0;
	int results = 0;
	int timing_checks = 0;
	logic busy = 1'b0;
	logic holding = 1'b0;
	logic ready_due = 1'b0;
	logic send_val_d = 1'b0;
	complex_t held_c;
	logic stall_en = 1'b0;
	logic [31:0] rand_state = 32'h9f6;
	logic [31:0] stall_state;

	tb_clock #(.PERIOD(4)) clock0 (.clk(clk));

	cmult_top dut0 (
		.clk(clk),
		.reset(reset),
		.recv_val(recv_val),
		.recv_rdy(recv_rdy),
		.a(a),
		.b(b),
		.send_val(send_val),
		.send_rdy(send_rdy),
		.c(c)
	);

	// ********************
	// Reference model
	// ********************

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// Exact signed product, floored by the arithmetic shift, then truncated.
	function automatic fixed_t ref_fixmul(input fixed_t x, input fixed_t y);
		logic signed [2*W-1:0] wx;
		logic signed [2*W-1:0] wy;
		logic signed [2*W-1:0] full;
		wx = x;
		wy = y;
		full = wx * wy;
		full = full >>> FRAC;
		return full[W-1:0];
	endfunction

	function automatic complex_t ref_cmult(input complex_t x, input complex_t y);
		fixed_t t0;
		fixed_t t1;
		fixed_t t2;
		complex_t r;
		t0 = ref_fixmul(x.re + x.im, y.re + y.im); // Operand sums wrap first.
		t1 = ref_fixmul(x.re, y.re);
		t2 = ref_fixmul(x.im, y.im);
		r.re = t1 - t2;
		r.im = t0 - t1 - t2;
		return r;
	endfunction

	function automatic complex_t make_complex(input fixed_t re, input fixed_t im);
		complex_t r;
		r.re = re;
		r.im = im;
		return r;
	endfunction

	function automatic fixed_t quarters(input int q);
		return fixed_t'(q) <<< (FRAC - 2);
	endfunction

	// ********************
	// Compare tasks
	// ********************

	task automatic check_complex(input string name, input complex_t expected,
			input complex_t actual);
		if (actual !== expected) begin
			errors++;
			$display("FAILED at %0t: %s expected re=%h im=%h, got re=%h im=%h",
				$time, name, expected.re, expected.im, actual.re, actual.im);
		end
	endtask

	task automatic check_flag(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			errors++;
			$display("FAILED at %0t: %s expected %b, got %b", $time, name, expected, actual);
		end
	endtask

	task automatic report_error(input string what);
		errors++;
		$display("Error at %0t: %s", $time, what);
	endtask

	// ********************
	// Stimulus
	// ********************

	// Called on a falling edge; returns on the falling edge after acceptance.
	task automatic send_op(input complex_t x, input complex_t y);
		exp_q.push_back(ref_cmult(x, y));
		recv_val = 1'b1;
		a = x;
		b = y;
		while (recv_rdy !== 1'b1)
			@(negedge clk);
		@(negedge clk);
		recv_val = 1'b0;
		a = ~x; // The DUT must not look at the inputs again.
		b = ~y;
	endtask

	task automatic next_word(output fixed_t w);
		logic [63:0] bits;
		rand_state = xorshift32(rand_state);
		bits[63:32] = rand_state;
		rand_state = xorshift32(rand_state);
		bits[31:0] = rand_state;
		case (bits[63:60])
			4'd0: w = {1'b1, {(W-1){1'b0}}}; // Most negative word.
			4'd1: w = {1'b0, {(W-1){1'b1}}};
			4'd2: w = {1'b1, {(W-2){1'b0}}, 1'b1};
			4'd3: w = '1;
			4'd4: w = ONE;
			4'd5: w = -ONE;
			default: w = bits[W-1:0];
		endcase
	endtask

	task automatic run_random(input int count);
		fixed_t w[4];
		for (int i = 0; i < count; i++) begin
			for (int k = 0; k < 4; k++)
				next_word(w[k]);
			send_op(make_complex(w[0], w[1]), make_complex(w[2], w[3]));
		end
	endtask

	task automatic wait_drained();
		while (busy || exp_q.size() != 0)
			@(negedge clk);
	endtask

	task automatic test_line(input string name, input int count, input int errs_before);
		$display("test %-12s %4d transactions, %0d errors", name, count, errors - errs_before);
	endtask

	always @(negedge clk) begin
		if (stall_en) begin
			stall_state = xorshift32(stall_state);
			send_rdy = (stall_state[1:0] != 2'b00); // Stall one cycle in four.
		end else
			send_rdy = 1'b1;
	end

	// ********************
	// Monitor and compare
	// ********************

	// Samples on the rising edge, where the DUT's registers take their inputs.
	always @(posedge clk) begin : monitor
		complex_t expected;
		cycles = cycles + 1;
		if (!reset) begin
			if (holding) begin
				check_flag("send_val", 1'b1, send_val);
				check_complex("c", held_c, c);
			end
			if (busy)
				check_flag("recv_rdy", 1'b0, recv_rdy);
			if (ready_due)
				check_flag("recv_rdy", 1'b1, recv_rdy);
			ready_due = 1'b0;
			if (send_val && !send_val_d) begin
				if (!busy)
					report_error("send_val rose with no accepted transaction");
				else if (cycles - accept_cycle - 1 != LATENCY)
					report_error($sformatf("result latency was %0d cycles instead of %0d",
						cycles - accept_cycle - 1, LATENCY));
				else
					timing_checks++;
			end
			if (send_val && send_rdy) begin
				if (exp_q.size() == 0)
					report_error("result transferred with no transaction pending");
				else begin
					expected = exp_q.pop_front();
					check_complex("c", expected, c);
					results++;
				end
				busy = 1'b0;
				ready_due = 1'b1;
			end
			holding = send_val && !send_rdy;
			held_c = c;
			if (recv_val && recv_rdy) begin
				accept_cycle = cycles;
				busy = 1'b1;
				accepted++;
			end
			send_val_d = send_val;
		end
	end

	initial begin : watchdog
		int n;
		for (n = 0; n < TIMEOUT_CYCLES; n++)
			@(posedge clk);
		$display("Timeout after %0d cycles with %0d results pending", n, exp_q.size());
		$display("** FAIL **");
		$finish;
	end

	// ********************
	// Test sequence
	// ********************

	initial begin
		int errs;
		reset = 1'b1;
		recv_val = 1'b0;
		a = '0;
		b = '0;
		send_rdy = 1'b1;
		stall_state = xorshift32(xorshift32(32'h9f6));
		repeat (RESET_CYCLES) @(negedge clk);
		reset = 1'b0;

		errs = errors;
		@(negedge clk);
		check_flag("recv_rdy", 1'b1, recv_rdy);
		check_flag("send_val", 1'b0, send_val);
		test_line("reset", 0, errs);

		errs = errors;
		send_op(make_complex(quarters(12), '0), make_complex(quarters(10), '0));
		send_op(make_complex('0, quarters(8)), make_complex('0, quarters(6)));
		send_op(make_complex(ONE, '0), make_complex(quarters(-5), quarters(3)));
		send_op(make_complex('0, ONE), make_complex(quarters(2), quarters(-8)));
		send_op(make_complex('0, '0), make_complex(quarters(28), quarters(-12)));
		send_op(make_complex(quarters(-6), quarters(9)), make_complex(quarters(-3), quarters(-12)));
		send_op(make_complex(quarters(-16), quarters(-16)), make_complex(quarters(-1), quarters(-2)));
		send_op(make_complex(fixed_t'(1), fixed_t'(-1)), make_complex(fixed_t'(3), fixed_t'(-5)));
		wait_drained();
		test_line("directed", N_DIRECTED, errs);

		errs = errors;
		run_random(N_RANDOM);
		wait_drained();
		test_line("extreme", N_RANDOM, errs);

		errs = errors;
		stall_en = 1'b1;
		run_random(N_STALL);
		wait_drained();
		stall_en = 1'b0;
		test_line("backpressure", N_STALL, errs);

		errs = errors;
		run_random(N_TIMING);
		wait_drained();
		test_line("timing", N_TIMING, errs);

		if (accepted != results || exp_q.size() != 0)
			report_error($sformatf("%0d transactions accepted but %0d results received",
				accepted, results));
		if (timing_checks != accepted)
			report_error($sformatf("only %0d of %0d results had their latency checked",
				timing_checks, accepted));
		$display("%0d transactions, %0d results, %0d latency checks, %0d errors",
			accepted, results, timing_checks, errors);
		if (errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

/* project.f */
+incdir+.
cmult_pkg.sv
fixed_iter_multiplier.sv
cmult_control.sv
cmult_datapath.sv
cmult_top.sv
tb_clock.sv
cmult_tb.sv

/* Bender.yml */
package:
  name: cmult

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - cmult_pkg.sv
      - fixed_iter_multiplier.sv
      - cmult_control.sv
      - cmult_datapath.sv
      - cmult_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_clock.sv
      - cmult_tb.sv
